/* hw/rob_pkg.sv */
package rob_pkg;

    localparam int XLEN  = 32;                       // Data, PC and instruction width
    localparam int REG_W = 5;                        // Architectural register index width

    localparam logic [6:0] OPC_STORE = 7'b0100011;   // RV32 store major opcode

    // Same 32-bit word, read as R-type or as S-type
    typedef union packed {
        struct packed {
            logic [6:0]       funct7;
            logic [REG_W-1:0] rs2;
            logic [REG_W-1:0] rs1;
            logic [2:0]       funct3;
            logic [REG_W-1:0] rd;                    // Destination register
            logic [6:0]       opcode;
        } r_fmt;
        struct packed {
            logic [6:0]       imm_hi;                // Offset bits 11:5
            logic [REG_W-1:0] rs2;                   // Store data source
            logic [REG_W-1:0] rs1;                   // Base address source
            logic [2:0]       funct3;                // Access width
            logic [4:0]       imm_lo;                // Offset bits 4:0, sits where rd would
            logic [6:0]       opcode;
        } s_fmt;
    } rob_inst_u;

endpackage

/* hw/rob_ptr_counter.sv */
`timescale 1ns/100ps

module rob_ptr_counter #(
    parameter int  DEPTH = 16,
    localparam int PTR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    input  logic              rst,
    input  rob_pkg::rob_inst_u disp_inst,            // Zero word means bubble
    input  logic              br_done,               // Branch resolves, tail moves back
    input  logic              flushing,              // Exception flush pending or running
    input  logic              pop,                   // Head retires
    input  logic [PTR_W-1:0]  trunc_tail,            // New tail after branch
    input  logic              clear,                 // Empty the buffer
    output logic              push,                  // Dispatch accepted
    output logic [PTR_W-1:0]  head,
    output logic [PTR_W-1:0]  tail,
    output logic              full
);

    logic [PTR_W:0]   count;                         // One bit wider to tell full from empty
    logic [PTR_W-1:0] trunc_diff;
    logic [PTR_W:0]   trunc_count;

    // Single place where dispatch acceptance is decided
    assign push = (disp_inst != '0) && !full && !br_done && !flushing;

    assign trunc_diff = trunc_tail - head;           // Wraps modulo DEPTH
    // Zero distance is either empty or a fully kept buffer, count already right
    assign trunc_count = (trunc_diff == '0) ? count : {1'b0, trunc_diff};

    assign full = (count == (PTR_W+1)'(DEPTH));      // Straight off the count register

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (pop) begin
                head <= head + PTR_W'(1);            // Natural wrap, DEPTH is a power of two
            end
            if (br_done) begin
                tail  <= trunc_tail;                 // Drop everything younger than branch
                count <= trunc_count - (PTR_W+1)'(pop);
            end else begin
                if (push) begin
                    tail <= tail + PTR_W'(1);
                end
                count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
            end
        end
    end

endmodule

/* hw/rob_entry_store.sv */
`timescale 1ns/100ps

module rob_entry_store #(
    parameter int  DEPTH = 16,
    localparam int PTR_W = $clog2(DEPTH)
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,         // Write dispatch at tail
    input  logic [PTR_W-1:0]           tail,
    input  logic [PTR_W-1:0]           head,
    input  logic                       clear,        // Wipe all entries
    input  rob_pkg::rob_inst_u         disp_inst,
    input  logic [rob_pkg::XLEN-1:0]   disp_pc,
    input  logic                       disp_reg_write,
    input  logic                       alu_done,
    input  logic [rob_pkg::XLEN-1:0]   alu_pc,
    input  logic [rob_pkg::XLEN-1:0]   alu_value,
    input  logic                       mul_done,
    input  logic [rob_pkg::XLEN-1:0]   mul_pc,
    input  logic [rob_pkg::XLEN-1:0]   mul_value,
    input  logic                       ls_done,
    input  logic [rob_pkg::XLEN-1:0]   ls_pc,
    input  logic [rob_pkg::XLEN-1:0]   ls_value,
    input  logic                       ls_exception,
    input  logic [rob_pkg::XLEN-1:0]   ls_store_addr,
    input  logic                       br_done,
    input  logic [rob_pkg::XLEN-1:0]   br_pc,
    input  logic [rob_pkg::XLEN-1:0]   br_target,
    input  logic                       pop,          // Head entry retires
    output logic [PTR_W-1:0]           trunc_tail,   // Slot after the branch
    output logic                       head_valid,
    output logic                       head_ready,
    output logic                       head_exc,
    output logic [rob_pkg::XLEN-1:0]   head_value,
    output rob_pkg::rob_inst_u         head_inst,
    output logic                       head_reg_write,
    output logic [rob_pkg::XLEN-1:0]   head_addr
);

    logic [DEPTH-1:0] valid;                         // Entry holds a live instruction
    logic [DEPTH-1:0] ready;                         // Result is in
    logic [DEPTH-1:0] exc;                           // Load/store fault

    logic                     rw_mem    [DEPTH];     // Register write flag
    logic [rob_pkg::XLEN-1:0] value_mem [DEPTH];
    rob_pkg::rob_inst_u       inst_mem  [DEPTH];
    logic [rob_pkg::XLEN-1:0] pc_mem    [DEPTH];     // Tag for completions
    logic [rob_pkg::XLEN-1:0] addr_mem  [DEPTH];     // Store address, zero unless ls wrote it

    logic [DEPTH-1:0] alu_hit, mul_hit, ls_hit, br_sel;
    logic [DEPTH-1:0] kill;                          // Younger than branch
    logic             br_hit;
    logic [PTR_W-1:0] br_idx;
    logic [PTR_W-1:0] span;                          // Slots from new tail up to old tail

    // Tag compare against waiting entries, one vector per source
    always_comb begin
        br_hit = 1'b0;
        br_idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            alu_hit[i] = alu_done && valid[i] && !ready[i] && (pc_mem[i] == alu_pc);
            mul_hit[i] = mul_done && valid[i] && !ready[i] && (pc_mem[i] == mul_pc);
            ls_hit[i]  = ls_done  && valid[i] && !ready[i] && (pc_mem[i] == ls_pc);
            br_sel[i]  = br_done  && valid[i] && !ready[i] && (pc_mem[i] == br_pc);
            if (br_sel[i]) begin
                br_hit = 1'b1;
                br_idx = PTR_W'(i);
            end
        end
    end

    assign trunc_tail = br_hit ? br_idx + PTR_W'(1) : tail; // No match keeps tail
    assign span       = tail - trunc_tail;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            // Circular range [trunc_tail, tail)
            kill[i] = br_hit && ((PTR_W'(i) - trunc_tail) < span);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            valid <= '0;
            ready <= '0;
            exc   <= '0;
        end else begin
            if (push) begin
                valid[tail] <= 1'b1;
                ready[tail] <= 1'b0;
                exc[tail]   <= 1'b0;
            end
            for (int i = 0; i < DEPTH; i++) begin
                if (alu_hit[i] || mul_hit[i] || ls_hit[i] || br_sel[i]) begin
                    ready[i] <= 1'b1;
                end
                if (ls_hit[i]) begin
                    exc[i] <= ls_exception;
                end
                if (kill[i]) begin
                    valid[i] <= 1'b0;                // Wrong-path entry
                    ready[i] <= 1'b0;
                end
            end
            if (pop) begin
                valid[head] <= 1'b0;
                ready[head] <= 1'b0;
            end
        end
    end

    // Payload, later source in the list overrides earlier
    always_ff @(posedge clk) begin
        if (push) begin
            rw_mem[tail]    <= disp_reg_write;
            value_mem[tail] <= '0;
            inst_mem[tail]  <= disp_inst;
            pc_mem[tail]    <= disp_pc;
            addr_mem[tail]  <= '0;
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (alu_hit[i]) value_mem[i] <= alu_value;
            if (mul_hit[i]) value_mem[i] <= mul_value;
            if (ls_hit[i]) begin
                value_mem[i] <= ls_value;
                addr_mem[i]  <= ls_store_addr;
            end
            if (br_sel[i]) value_mem[i] <= br_target; // Jump target as result
        end
    end

    assign head_valid     = valid[head];
    assign head_ready     = ready[head];
    assign head_exc       = exc[head];
    assign head_value     = value_mem[head];
    assign head_inst      = inst_mem[head];
    assign head_reg_write = rw_mem[head];
    assign head_addr      = addr_mem[head];

endmodule

/* hw/rob_commit_fsm.sv */
`timescale 1ns/100ps

module rob_commit_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       head_valid,
    input  logic                       head_ready,
    input  logic                       head_exc,
    input  logic [rob_pkg::XLEN-1:0]   head_value,
    input  rob_pkg::rob_inst_u         head_inst,
    input  logic                       head_reg_write,
    input  logic [rob_pkg::XLEN-1:0]   head_addr,
    output logic                       pop,          // Retire head this edge
    output logic                       clear,        // Empty pointers and entries
    output logic                       flushing,     // Hold off dispatch
    output logic                       commit_valid,
    output logic [rob_pkg::XLEN-1:0]   commit_value,
    output logic [rob_pkg::REG_W-1:0]  commit_dest,
    output logic                       commit_reg_write,
    output logic                       commit_store,
    output logic [rob_pkg::XLEN-1:0]   commit_addr,
    output logic                       exception
);

    localparam logic RUN   = 1'b0;
    localparam logic FLUSH = 1'b1;

    logic                      state;
    logic                      head_go;              // Head done, FSM free to act
    logic                      is_store;
    logic [rob_pkg::REG_W-1:0] dest;

    assign head_go  = (state == RUN) && head_valid && head_ready;
    assign pop      = head_go && !head_exc;
    assign clear    = (state == FLUSH);
    assign flushing = clear || (head_go && head_exc); // Flush about to start or running

    // Opcode through the S view, rd through the R view
    assign is_store = (head_inst.s_fmt.opcode == rob_pkg::OPC_STORE);
    assign dest     = is_store ? '0 : head_inst.r_fmt.rd; // rd slot is imm_lo for stores

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RUN;
        end else begin
            case (state)
                RUN:     if (head_go && head_exc) state <= FLUSH;
                default: state <= RUN;               // Flush takes one cycle
            endcase
        end
    end

    // Retire outputs, zero whenever commit_valid is low
    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid     <= 1'b0;
            commit_value     <= '0;
            commit_dest      <= '0;
            commit_reg_write <= 1'b0;
            commit_store     <= 1'b0;
            commit_addr      <= '0;
            exception        <= 1'b0;
        end else begin
            commit_valid     <= pop;
            commit_value     <= pop ? head_value : '0;
            commit_dest      <= pop ? dest : '0;
            commit_reg_write <= pop && head_reg_write;
            commit_store     <= pop && is_store;
            commit_addr      <= pop ? head_addr : '0;
            exception        <= head_go && head_exc; // Single pulse, FSM leaves RUN
        end
    end

endmodule

/* hw/rob_top.sv */
`timescale 1ns/100ps

module rob_top #(
    parameter int DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  rob_pkg::rob_inst_u         disp_inst,
    input  logic [rob_pkg::XLEN-1:0]   disp_pc,
    input  logic                       disp_reg_write,
    input  logic                       alu_done,
    input  logic [rob_pkg::XLEN-1:0]   alu_pc,
    input  logic [rob_pkg::XLEN-1:0]   alu_value,
    input  logic                       mul_done,
    input  logic [rob_pkg::XLEN-1:0]   mul_pc,
    input  logic [rob_pkg::XLEN-1:0]   mul_value,
    input  logic                       ls_done,
    input  logic [rob_pkg::XLEN-1:0]   ls_pc,
    input  logic [rob_pkg::XLEN-1:0]   ls_value,
    input  logic                       ls_exception,
    input  logic [rob_pkg::XLEN-1:0]   ls_store_addr,
    input  logic                       br_done,
    input  logic [rob_pkg::XLEN-1:0]   br_pc,
    input  logic [rob_pkg::XLEN-1:0]   br_target,
    output logic                       commit_valid,
    output logic [rob_pkg::XLEN-1:0]   commit_value,
    output logic [rob_pkg::REG_W-1:0]  commit_dest,
    output logic                       commit_reg_write,
    output logic                       commit_store,
    output logic [rob_pkg::XLEN-1:0]   commit_addr,
    output logic                       exception,
    output logic                       full
);

    localparam int PTR_W = $clog2(DEPTH);

    logic                     push, pop, clear, flushing;
    logic [PTR_W-1:0]         head, tail, trunc_tail;
    logic                     head_valid, head_ready, head_exc, head_reg_write;
    logic [rob_pkg::XLEN-1:0] head_value, head_addr;
    rob_pkg::rob_inst_u       head_inst;

    rob_ptr_counter #(.DEPTH(DEPTH)) u_ptr (
        .clk        (clk),
        .rst        (rst),
        .disp_inst  (disp_inst),
        .br_done    (br_done),
        .flushing   (flushing),
        .pop        (pop),
        .trunc_tail (trunc_tail),
        .clear      (clear),
        .push       (push),
        .head       (head),
        .tail       (tail),
        .full       (full)
    );

    rob_entry_store #(.DEPTH(DEPTH)) u_store (
        .clk            (clk),
        .rst            (rst),
        .push           (push),
        .tail           (tail),
        .head           (head),
        .clear          (clear),
        .disp_inst      (disp_inst),
        .disp_pc        (disp_pc),
        .disp_reg_write (disp_reg_write),
        .alu_done       (alu_done),
        .alu_pc         (alu_pc),
        .alu_value      (alu_value),
        .mul_done       (mul_done),
        .mul_pc         (mul_pc),
        .mul_value      (mul_value),
        .ls_done        (ls_done),
        .ls_pc          (ls_pc),
        .ls_value       (ls_value),
        .ls_exception   (ls_exception),
        .ls_store_addr  (ls_store_addr),
        .br_done        (br_done),
        .br_pc          (br_pc),
        .br_target      (br_target),
        .pop            (pop),
        .trunc_tail     (trunc_tail),
        .head_valid     (head_valid),
        .head_ready     (head_ready),
        .head_exc       (head_exc),
        .head_value     (head_value),
        .head_inst      (head_inst),
        .head_reg_write (head_reg_write),
        .head_addr      (head_addr)
    );

    rob_commit_fsm u_commit (
        .clk              (clk),
        .rst              (rst),
        .head_valid       (head_valid),
        .head_ready       (head_ready),
        .head_exc         (head_exc),
        .head_value       (head_value),
        .head_inst        (head_inst),
        .head_reg_write   (head_reg_write),
        .head_addr        (head_addr),
        .pop              (pop),
        .clear            (clear),
        .flushing         (flushing),
        .commit_valid     (commit_valid),
        .commit_value     (commit_value),
        .commit_dest      (commit_dest),
        .commit_reg_write (commit_reg_write),
        .commit_store     (commit_store),
        .commit_addr      (commit_addr),
        .exception        (exception)
    );

endmodule

/* testbench/rob_properties.sv */
`timescale 1ns/100ps

module rob_properties #(
    parameter int PTR_W = 4
) (
    input logic             clk,
    input logic             rst,
    input logic             exception,
    input logic             commit_valid,
    input logic             full,
    input logic             br_done,
    input logic             clear,
    input logic [PTR_W-1:0] tail
);

    // Flush lasts one cycle
    a_exc_single: assert property (@(posedge clk) disable iff (rst)
        exception |=> !exception)
        else $error("exception high two cycles in a row");

    a_commit_or_exc: assert property (@(posedge clk) disable iff (rst)
        !(commit_valid && exception))
        else $error("commit_valid and exception high together");

    // Only a branch or flush moves the tail of a full buffer
    a_full_tail: assert property (@(posedge clk) disable iff (rst)
        full && !br_done && !clear |=> $stable(tail))
        else $error("tail moved while full");

endmodule

bind rob_top rob_properties #(.PTR_W($clog2(DEPTH))) u_props (
    .clk          (clk),
    .rst          (rst),
    .exception    (exception),
    .commit_valid (commit_valid),
    .full         (full),
    .br_done      (br_done),
    .clear        (clear),
    .tail         (tail)
);

/* testbench/rob_tb.sv */
`timescale 1ns/100ps

module rob_tb;

    localparam int DEPTH       = 16;
    localparam int NUM_TESTS   = 5;
    localparam int CLK_NS      = 20;
    localparam int WATCHDOG_NS = (NUM_TESTS * 200 + 100) * CLK_NS; // Test budget plus margin

    typedef struct packed {
        logic [rob_pkg::XLEN-1:0]  pc;
        logic [rob_pkg::XLEN-1:0]  value;
        logic [rob_pkg::REG_W-1:0] dest;
        logic                      reg_write;
        logic                      store;
        logic [rob_pkg::XLEN-1:0]  addr;
    } exp_commit_t;

    logic clk, rst;
    rob_pkg::rob_inst_u disp_inst;
    logic [rob_pkg::XLEN-1:0] disp_pc, alu_pc, alu_value, mul_pc, mul_value;
    logic [rob_pkg::XLEN-1:0] ls_pc, ls_value, ls_store_addr, br_pc, br_target;
    logic disp_reg_write, alu_done, mul_done, ls_done, ls_exception, br_done;
    logic commit_valid, commit_reg_write, commit_store, exception, full;
    logic [rob_pkg::XLEN-1:0]  commit_value, commit_addr;
    logic [rob_pkg::REG_W-1:0] commit_dest;

    exp_commit_t exp_q[$];                           // Commits still to come in age order
    bit          done_pc[logic [rob_pkg::XLEN-1:0]]; // PCs whose result was sent
    logic [31:0] lfsr_state = 32'h8ac0;
    logic [rob_pkg::XLEN-1:0] next_pc = 32'h1000;
    int mismatch_count = 0;
    int other_count    = 0;
    int exc_count      = 0;
    bit exc_expected   = 0;

    rob_top #(.DEPTH(DEPTH)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic rob_pkg::rob_inst_u reg_format_inst(input logic [rob_pkg::REG_W-1:0] rd);
        rob_pkg::rob_inst_u u;
        u.r_fmt.funct7 = 7'h01;
        u.r_fmt.rs2    = 5'(lfsr_bits(5));
        u.r_fmt.rs1    = 5'(lfsr_bits(5));
        u.r_fmt.funct3 = 3'h0;
        u.r_fmt.rd     = rd;
        u.r_fmt.opcode = 7'b0110011;                 // OP class
        return u;
    endfunction

    function automatic rob_pkg::rob_inst_u store_format_inst(input logic [4:0] imm_lo);
        rob_pkg::rob_inst_u u;
        u.s_fmt.imm_hi = 7'h02;
        u.s_fmt.rs2    = 5'd7;
        u.s_fmt.rs1    = 5'd9;
        u.s_fmt.funct3 = 3'h2;                       // Word store
        u.s_fmt.imm_lo = imm_lo;
        u.s_fmt.opcode = rob_pkg::OPC_STORE;
        return u;
    endfunction

    task automatic check_commit(input exp_commit_t e);
        if (commit_value !== e.value || commit_dest !== e.dest ||
            commit_reg_write !== e.reg_write || commit_store !== e.store ||
            commit_addr !== e.addr) begin
            mismatch_count++;
            $display("MISMATCH %0t: commit pc %h got val %h rd %0d rw %b st %b addr %h, ",
                     $time, e.pc, commit_value, commit_dest, commit_reg_write,
                     commit_store, commit_addr);
            $display("  expected val %h rd %0d rw %b st %b addr %h",
                     e.value, e.dest, e.reg_write, e.store, e.addr);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // Commit and exception monitor sampling at the falling edge
    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            if (exp_q.size() == 0) begin
                other_count++;
                $display("Unexpected commit at %0t with value %h", $time, commit_value);
            end else begin
                if (!done_pc.exists(exp_q[0].pc)) begin
                    other_count++;
                    $display("Commit of pc %h at %0t before its result", exp_q[0].pc, $time);
                end
                check_commit(exp_q.pop_front());
            end
        end else if (!rst) begin
            check_commit('0);                        // Retire fields read zero when idle
        end
        if (!rst && exception) begin
            if (!exc_expected) begin
                other_count++;
                $display("Unexpected exception pulse at %0t", $time);
            end
            exc_expected = 0;                        // A second pulse is an error
            exc_count++;
        end
    end

    task automatic drive_idle();
        disp_inst      <= '0;
        disp_pc        <= '0;
        disp_reg_write <= 1'b0;
        alu_done       <= 1'b0;
        mul_done       <= 1'b0;
        ls_done        <= 1'b0;
        ls_exception   <= 1'b0;
        br_done        <= 1'b0;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        drive_idle();
    endtask

    // keep says whether the model expects the entry to be accepted
    task automatic dispatch(input rob_pkg::rob_inst_u inst, input logic rw,
                            input logic [rob_pkg::REG_W-1:0] dest, input logic store,
                            input bit keep);
        exp_commit_t e;
        @(posedge clk);
        drive_idle();
        disp_inst      <= inst;
        disp_pc        <= next_pc;
        disp_reg_write <= rw;
        e.pc        = next_pc;
        e.value     = '0;
        e.dest      = dest;
        e.reg_write = rw;
        e.store     = store;
        e.addr      = '0;
        if (keep) exp_q.push_back(e);
        next_pc += 4;
    endtask

    // Unit 0 is the ALU, 1 the multiplier and 2 load/store
    task automatic complete(input int unit, input logic [rob_pkg::XLEN-1:0] pc,
                            input logic [rob_pkg::XLEN-1:0] value,
                            input logic [rob_pkg::XLEN-1:0] addr, input logic exc);
        @(posedge clk);
        drive_idle();
        case (unit)
            0: begin
                alu_done  <= 1'b1;
                alu_pc    <= pc;
                alu_value <= value;
            end
            1: begin
                mul_done  <= 1'b1;
                mul_pc    <= pc;
                mul_value <= value;
            end
            default: begin
                ls_done       <= 1'b1;
                ls_pc         <= pc;
                ls_value      <= value;
                ls_store_addr <= addr;
                ls_exception  <= exc;
            end
        endcase
        foreach (exp_q[i]) begin
            if (exp_q[i].pc == pc) begin
                exp_q[i].value = value;
                if (unit == 2) exp_q[i].addr = addr;
            end
        end
        done_pc[pc] = 1;
    endtask

    task automatic branch(input logic [rob_pkg::XLEN-1:0] pc,
                          input logic [rob_pkg::XLEN-1:0] target);
        @(posedge clk);
        drive_idle();
        br_done   <= 1'b1;
        br_pc     <= pc;
        br_target <= target;
        foreach (exp_q[i]) begin
            if (exp_q[i].pc == pc) exp_q[i].value = target;
        end
        done_pc[pc] = 1;
    endtask

    task automatic wait_drain(input string test);
        int n;
        n = 0;
        idle_cycle();
        while (exp_q.size() != 0 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            other_count++;
            $display("%s: %0d commits never arrived", test, exp_q.size());
            exp_q.delete();
        end
        repeat (3) @(negedge clk);                   // Catch stray commits
    endtask

    task automatic in_order_retire();
        logic [rob_pkg::XLEN-1:0] pcs[6];
        int order[6];
        int j, t;
        for (int i = 0; i < 6; i++) begin
            pcs[i]   = next_pc;
            order[i] = i;
            dispatch(reg_format_inst(5'(i + 1)), 1'b1, 5'(i + 1), 1'b0, 1);
        end
        for (int i = 5; i > 0; i--) begin            // Shuffle the completion order
            j = lfsr_bits(8) % (i + 1);
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < 6; i++) begin
            complete(int'(lfsr_bits(1)), pcs[order[i]], lfsr_bits(32), '0, 1'b0);
        end
        wait_drain("out of order");
    endtask

    task automatic bubbles_and_full();
        logic [rob_pkg::XLEN-1:0] pcs[DEPTH];
        for (int i = 0; i < DEPTH + 2; i++) begin
            dispatch('0, 1'b1, '0, 1'b0, 0);         // Bubble creates no entry
            if (i < DEPTH) pcs[i] = next_pc;
            dispatch(reg_format_inst(5'(i + 1)), 1'b1, 5'(i + 1), 1'b0, i < DEPTH);
        end
        @(negedge clk);
        check_flag(full, 1'b1, "full after DEPTH dispatches");
        for (int i = 0; i < DEPTH; i++) complete(0, pcs[i], lfsr_bits(32), '0, 1'b0);
        wait_drain("bubbles and full");
        check_flag(full, 1'b0, "full after drain");
    endtask

    task automatic store_commit();
        logic [rob_pkg::XLEN-1:0] pc;
        pc = next_pc;
        dispatch(store_format_inst(5'h1d), 1'b0, '0, 1'b1, 1); // Store retires with no rd
        complete(2, pc, lfsr_bits(32), 32'h8000_0040, 1'b0);
        wait_drain("store");
    endtask

    task automatic branch_truncation();
        logic [rob_pkg::XLEN-1:0] pcs[5];
        logic [rob_pkg::XLEN-1:0] npc;
        for (int i = 0; i < 5; i++) begin
            pcs[i] = next_pc;
            dispatch(reg_format_inst(5'(i + 10)), 1'b1, 5'(i + 10), 1'b0, 1);
        end
        branch(pcs[1], 32'h0000_2468);
        exp_q.delete(4);                             // Younger than the branch
        exp_q.delete(3);
        exp_q.delete(2);
        for (int i = 2; i < 5; i++) complete(1, pcs[i], lfsr_bits(32), '0, 1'b0);
        complete(0, pcs[0], lfsr_bits(32), '0, 1'b0);
        for (int i = 0; i < 2; i++) begin
            npc = next_pc;
            dispatch(reg_format_inst(5'(i + 20)), 1'b1, 5'(i + 20), 1'b0, 1);
            complete(0, npc, lfsr_bits(32), '0, 1'b0);
        end
        wait_drain("branch");
    endtask

    task automatic exception_flush();
        logic [rob_pkg::XLEN-1:0] pcs[4];
        logic [rob_pkg::XLEN-1:0] npc;
        int start, n;
        start = exc_count;
        for (int i = 0; i < 4; i++) begin
            pcs[i] = next_pc;
            dispatch(reg_format_inst(5'(i + 3)), 1'b1, 5'(i + 3), 1'b0, 1);
        end
        exc_expected = 1;
        complete(2, pcs[2], lfsr_bits(32), 32'h44, 1'b1);
        exp_q.delete(3);                             // Flushed entries never retire
        exp_q.delete(2);
        complete(0, pcs[3], lfsr_bits(32), '0, 1'b0);
        complete(1, pcs[0], lfsr_bits(32), '0, 1'b0);
        complete(0, pcs[1], lfsr_bits(32), '0, 1'b0);
        idle_cycle();
        n = 0;
        @(negedge clk);
        while (!exception && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!exception) begin
            other_count++;
            $display("Exception pulse never arrived");
        end
        @(negedge clk);
        check_flag(exception, 1'b0, "exception one cycle after pulse");
        npc = next_pc;
        dispatch(reg_format_inst(5'd30), 1'b1, 5'd30, 1'b0, 1);
        complete(1, npc, lfsr_bits(32), '0, 1'b0);
        wait_drain("exception");
        if (exc_count != start + 1) begin
            other_count++;
            $display("Exception pulsed %0d times", exc_count - start);
        end
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("Run stopped by watchdog at %0t", $time);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        drive_idle();
        alu_pc        = '0;
        alu_value     = '0;
        mul_pc        = '0;
        mul_value     = '0;
        ls_pc         = '0;
        ls_value      = '0;
        ls_store_addr = '0;
        br_pc         = '0;
        br_target     = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag(full, 1'b0, "full after reset");
        check_flag(exception, 1'b0, "exception after reset");
        in_order_retire();
        bubbles_and_full();
        store_commit();
        branch_truncation();
        exception_flush();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* src.f */
hw/rob_pkg.sv
hw/rob_ptr_counter.sv
hw/rob_entry_store.sv
hw/rob_commit_fsm.sv
hw/rob_top.sv
testbench/rob_properties.sv
testbench/rob_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = rob_tb
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
